// ==== compile.f ====
+incdir+rtl
rtl/axi_pkg.sv
rtl/ifu_pkg.sv
rtl/pc_gen.sv
rtl/rd_wait_timer.sv
rtl/fetch_align.sv
rtl/axi_rd_fsm.sv
rtl/ifu_top.sv
verif/tb_ifu_top.sv

// ==== verif/tb_ifu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ifu_settings.svh"

module tb_ifu_top;

    localparam int PERIOD       = 100;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_FETCH    = 400;
    localparam int MISS_WORST   = `IFU_RD_TIMEOUT + 16;   // timeout plus halt and restart
    localparam logic [31:0] SEED = 32'h6620;

    logic                 clock;
    logic                 reset;
    logic                 redirect;
    logic [`IFU_XLEN-1:0] redirect_pc;
    axi_pkg::ar_chan_t    ar;
    logic                 ar_ready;
    axi_pkg::r_chan_t     r_chan;
    logic                 r_ready;
    ifu_pkg::fetch_rsp_t  rsp;

    logic [63:0]          mem [0:63];     // indexed by addr[8:3]
    integer               mem_seed;
    integer               stim_seed;
    logic [`IFU_XLEN-1:0] exp_pc;         // pc of the request in flight
    logic                 read_err;       // outcome of the last bus read
    logic                 read_hang;      // last bus read was never answered
    int                   hangs;

    ifu_top ifu_top_inst (
        .clock         (clock),
        .reset         (reset),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc),
        .ar_o          (ar),
        .ar_ready_i    (ar_ready),
        .r_i           (r_chan),
        .r_ready_o     (r_ready),
        .rsp_o         (rsp)
    );

    always #(PERIOD / 2) clock = ~clock;

    task automatic fail_now(input string msg);
        $display("Error at time %0t: %s", $time, msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_rsp(input ifu_pkg::fetch_rsp_t got, input ifu_pkg::fetch_rsp_t exp);
        if (got !== exp) begin
            fail_now($sformatf("fetch got pc %h instr %h err %b, expected pc %h instr %h err %b",
                got.pc, got.instr, got.err, exp.pc, exp.instr, exp.err));
        end
    endtask

    task automatic check_ar(input axi_pkg::ar_chan_t got, input axi_pkg::ar_chan_t exp);
        if (got !== exp) begin
            fail_now($sformatf("AR got addr %h len %h size %h burst %h, expected addr %h",
                got.addr, got.len, got.size, got.burst, exp.addr));
        end
    endtask

    // 4-byte aligned target inside the modeled memory window
    function automatic logic [`IFU_XLEN-1:0] pick_target_pc();
        logic [31:0] off;
        off = $random(stim_seed);
        return `IFU_RESET_PC + {55'h0, off[8:2], 2'b00};
    endfunction

    initial begin
        clock       = 1'b0;
        reset       = 1'b0;
        redirect    = 1'b0;
        redirect_pc = '0;
        ar_ready    = 1'b0;
        r_chan      = '0;
        mem_seed    = SEED;
        stim_seed   = SEED;
        read_err    = 1'b0;
        read_hang   = 1'b0;
        hangs       = 0;
        repeat (RESET_CYCLES) @(posedge clock);
        reset <= 1'b1;
    end

    // axi slave with random stalls and one read at a time
    initial begin : axi_memory
        axi_pkg::ar_chan_t ar_exp;
        integer            delay;
        integer            hang_roll;
        integer            bad_roll;
        int                rd_num;
        logic              hang;
        logic              bad;
        for (int i = 0; i < 64; i++) begin
            mem[i] = {$random(mem_seed), $random(mem_seed)};
        end
        rd_num = 0;
        @(posedge reset);
        forever begin
            @(posedge clock);
            if (ar.valid) begin
                delay = $unsigned($random(mem_seed)) % 6;
                repeat (delay) @(posedge clock);
                ar_ready <= 1'b1;
                @(posedge clock);                 // handshake in the cycle just ended
                ar_ready <= 1'b0;
                if (!ar.valid) fail_now("AR valid dropped before its handshake");
                ar_exp       = '0;
                ar_exp.valid = 1'b1;
                ar_exp.addr  = {exp_pc[`IFU_XLEN-1:3], 3'b000};
                ar_exp.len   = 8'd0;
                ar_exp.size  = axi_pkg::SIZE_8B;
                ar_exp.burst = axi_pkg::BURST_INCR;
                ar_exp.prot  = axi_pkg::PROT_DATA;
                ar_exp.cache = axi_pkg::CACHE_NONBUF;
                check_ar(ar, ar_exp);
                rd_num    = rd_num + 1;
                hang_roll = $random(mem_seed) & 31;
                bad_roll  = $random(mem_seed) & 15;
                hang      = (rd_num == 9) || (hang_roll == 0);   // read 9 always hangs
                bad       = !hang && ((rd_num == 5) || (bad_roll == 0));
                read_err  = hang || bad;
                read_hang = hang;
                if (hang) begin
                    hangs = hangs + 1;            // never answered until the next AR
                end else begin
                    delay = $unsigned($random(mem_seed)) % 6;
                    repeat (delay) @(posedge clock);
                    r_chan.valid <= 1'b1;
                    r_chan.data  <= mem[ar_exp.addr[8:3]];
                    if (bad) begin
                        r_chan.resp <= axi_pkg::SLVERR;
                    end else begin
                        r_chan.resp <= axi_pkg::OKAY;
                    end
                    r_chan.last  <= 1'b1;
                    r_chan.id    <= '0;
                    @(posedge clock);
                    while (!r_ready) @(posedge clock);
                    r_chan <= '0;
                end
            end
        end
    end

    // reference model with checks and redirect stimulus
    initial begin : monitor
        ifu_pkg::fetch_rsp_t  got;
        ifu_pkg::fetch_rsp_t  exp;
        logic                 redir_s;
        logic [`IFU_XLEN-1:0] redir_pc_s;
        logic [`IFU_XLEN-1:0] pend_pc;
        logic                 pend;
        logic                 halted;
        logic [`IFU_XLEN-4:0] tag;
        logic                 tag_ok;
        logic                 hit;
        logic [63:0]          word;
        logic                 r_hs_cur;
        logic                 r_hs_prev;
        int                   halt_wait;
        int                   gap;
        int                   wait_cyc;
        int                   ar_count;
        int                   fetches;
        int                   hits;
        int                   errs;
        int                   redirects;
        exp_pc    = `IFU_RESET_PC;
        pend      = 1'b0;
        pend_pc   = '0;
        halted    = 1'b0;
        tag       = '0;
        tag_ok    = 1'b0;
        r_hs_prev = 1'b0;
        halt_wait = 0;
        gap       = 0;
        wait_cyc  = 0;
        ar_count  = 0;
        fetches   = 0;
        hits      = 0;
        errs      = 0;
        redirects = 0;
        @(posedge reset);
        if (ar.valid || r_ready || rsp.valid || rsp.err) begin
            fail_now("AXI or fetch outputs active out of reset");
        end
        while (fetches < NUM_FETCH) begin
            @(posedge clock);
            got        = rsp;                     // values of the cycle just ended
            redir_s    = redirect;
            redir_pc_s = redirect_pc;
            r_hs_cur   = r_chan.valid && r_ready;
            if (ar.valid && ar_ready) ar_count = ar_count + 1;
            if (ar.valid || r_ready) wait_cyc = wait_cyc + 1;   // read outstanding
            gap = gap + 1;
            if (!got.valid && got.err !== 1'b0) fail_now("err set without a response");
            if (halted) begin
                if (ar.valid || got.valid) fail_now("fetch activity while the pc is halted");
                if (redir_s) begin
                    exp_pc = redir_pc_s;          // restart at once
                    halted = 1'b0;
                end
            end else if (got.valid) begin
                hit = tag_ok && (exp_pc[`IFU_XLEN-1:3] == tag);
                if (hit) begin
                    if (ar_count != 0) fail_now("AR issued for a word already held");
                    if (gap != 2) fail_now($sformatf("hit delivered after %0d cycles", gap));
                    hits = hits + 1;
                end else if (ar_count != 1) begin
                    fail_now($sformatf("miss delivered after %0d AR handshakes", ar_count));
                end else if (read_hang) begin
                    if (wait_cyc != `IFU_RD_TIMEOUT) begin
                        fail_now($sformatf("hung read ended after %0d wait cycles", wait_cyc));
                    end
                end else if (!r_hs_prev) begin
                    fail_now("miss delivered without an R handshake in the cycle before");
                end
                word      = mem[exp_pc[8:3]];
                exp       = '0;
                exp.valid = 1'b1;
                exp.pc    = exp_pc;
                exp.err   = hit ? 1'b0 : read_err;
                if (!exp.err) exp.instr = exp_pc[2] ? word[63:32] : word[31:0];
                check_rsp(got, exp);
                if (!hit) begin
                    tag    = exp_pc[`IFU_XLEN-1:3];
                    tag_ok = !exp.err;            // bad word is never reused
                end
                if (exp.err) errs = errs + 1;
                if (redir_s || pend) begin
                    exp_pc = redir_s ? redir_pc_s : pend_pc;
                end else if (exp.err) begin
                    halted    = 1'b1;
                    halt_wait = $unsigned($random(stim_seed)) % 4;
                end else begin
                    exp_pc = exp_pc + 4;
                end
                pend     = 1'b0;
                fetches  = fetches + 1;
                gap      = 0;
                wait_cyc = 0;
                ar_count = 0;
            end else if (redir_s) begin
                pend = 1'b1;                      // held until the next deliver
            end
            if (redir_s) pend_pc = redir_pc_s;
            redirect <= 1'b0;
            if (halted) begin
                if (halt_wait == 0) begin
                    redirect    <= 1'b1;          // half the time retry the same word
                    redirect_pc <= ($random(stim_seed) & 1) ? exp_pc : pick_target_pc();
                end else begin
                    halt_wait = halt_wait - 1;
                end
            end else if ((ar.valid || r_ready) && (($random(stim_seed) & 15) == 0)) begin
                redirect    <= 1'b1;
                redirect_pc <= pick_target_pc();
                redirects = redirects + 1;
            end
            r_hs_prev = r_hs_cur;
        end
        $display("fetches %0d hits %0d errors %0d hangs %0d redirects %0d",
            fetches, hits, errs, hangs, redirects);
        if (hits == 0 || errs == 0 || hangs == 0 || redirects == 0) begin
            fail_now("run ended without hits, errors, hung reads and redirects all seen");
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

    // every fetch allowed the worst-case miss time
    initial begin : watchdog
        #(PERIOD * (RESET_CYCLES + NUM_FETCH * MISS_WORST));
        $display("watchdog expired before all fetches were delivered");
        $display("TEST RESULT: FAIL");
        $fatal(1, "run timed out");
    end

endmodule

`default_nettype wire

// ==== rtl/ifu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ifu_settings.svh"

module ifu_top (
    input  wire logic                 clock,
    input  wire logic                 reset,
    input  wire logic                 redirect_i,
    input  wire logic [`IFU_XLEN-1:0] redirect_pc_i,
    output axi_pkg::ar_chan_t         ar_o,
    input  wire logic                 ar_ready_i,
    input  wire axi_pkg::r_chan_t     r_i,
    output logic                      r_ready_o,
    output ifu_pkg::fetch_rsp_t       rsp_o
);

    ifu_pkg::fetch_req_t  req;
    logic                 wait_en;
    logic                 expire;
    logic                 load;
    logic                 deliver;       // also advances the pc
    logic [`IFU_XLEN-1:0] deliver_pc;
    logic                 err;

    pc_gen pc_gen_inst (
        .clock         (clock),
        .reset         (reset),
        .redirect_i    (redirect_i),
        .redirect_pc_i (redirect_pc_i),
        .advance_i     (deliver),
        .adv_err_i     (err),
        .req_o         (req)
    );

    axi_rd_fsm axi_rd_fsm_inst (
        .clock        (clock),
        .reset        (reset),
        .req_i        (req),
        .ar_o         (ar_o),
        .ar_ready_i   (ar_ready_i),
        .r_i          (r_i),
        .r_ready_o    (r_ready_o),
        .wait_en_o    (wait_en),
        .expire_i     (expire),
        .load_o       (load),
        .deliver_o    (deliver),
        .deliver_pc_o (deliver_pc),
        .err_o        (err)
    );

    rd_wait_timer rd_wait_timer_inst (
        .clock    (clock),
        .reset    (reset),
        .en_i     (wait_en),
        .expire_o (expire)
    );

    fetch_align fetch_align_inst (
        .clock     (clock),
        .reset     (reset),
        .load_i    (load),
        .data_i    (r_i.data),    // captured only on load
        .deliver_i (deliver),
        .pc_i      (deliver_pc),
        .err_i     (err),
        .rsp_o     (rsp_o)
    );

endmodule

`default_nettype wire

// ==== rtl/axi_rd_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ifu_settings.svh"

module axi_rd_fsm (
    input  wire logic                 clock,
    input  wire logic                 reset,
    input  wire ifu_pkg::fetch_req_t  req_i,
    output axi_pkg::ar_chan_t         ar_o,
    input  wire logic                 ar_ready_i,
    input  wire axi_pkg::r_chan_t     r_i,
    output logic                      r_ready_o,
    output logic                      wait_en_o,      // read outstanding
    input  wire logic                 expire_i,       // timer ran out
    output logic                      load_o,         // good r beat, store data
    output logic                      deliver_o,
    output logic [`IFU_XLEN-1:0]      deliver_pc_o,
    output logic                      err_o
);

    typedef enum logic [2:0] {
        IDLE    = 3'd0,
        AR_WAIT = 3'd1,
        R_WAIT  = 3'd2,
        DELIVER = 3'd3,
        HOLD    = 3'd4
    } state_e;

    state_e               state_q;
    state_e               state_d;
    logic [`IFU_XLEN-1:0] pc_q;        // captured request pc
    logic [`IFU_XLEN-4:0] tag_q;       // pc[63:3] of the held word
    logic                 tag_vld_q;
    logic                 err_q;       // error for the next deliver
    logic                 tag_hit;
    logic                 start;
    logic                 ar_hs;
    logic                 r_hs;
    logic                 r_ok;

    assign tag_hit = tag_vld_q && (req_i.pc[`IFU_XLEN-1:3] == tag_q);
    assign start   = req_i.valid && ((state_q == IDLE) || (state_q == HOLD));
    assign ar_hs   = ar_o.valid && ar_ready_i;
    assign r_hs    = r_ready_o && r_i.valid;
    assign r_ok    = (r_i.resp == axi_pkg::OKAY);

    // next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (req_i.valid) state_d = AR_WAIT;
            end
            AR_WAIT: begin
                if (expire_i) begin
                    state_d = DELIVER;          // abandon, timeout wins
                end else if (ar_hs) begin
                    state_d = R_WAIT;
                end
            end
            R_WAIT: begin
                if (r_hs || expire_i) state_d = DELIVER;  // data wins a tie
            end
            DELIVER: begin
                state_d = HOLD;                 // always one cycle
            end
            HOLD: begin
                if (req_i.valid) begin
                    state_d = tag_hit ? DELIVER : AR_WAIT;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    // control state
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state_q   <= IDLE;
            tag_vld_q <= 1'b0;
            err_q     <= 1'b0;
        end else begin
            state_q <= state_d;
            if (r_hs) begin
                tag_vld_q <= r_ok;              // bad resp drops the word
                err_q     <= !r_ok;
            end else if (wait_en_o && expire_i) begin
                tag_vld_q <= 1'b0;              // held word no longer trusted
                err_q     <= 1'b1;
            end else if (start) begin
                err_q <= 1'b0;                  // hit delivers clean
            end
        end
    end

    // request pc and word tag
    always_ff @(posedge clock) begin
        if (start) begin
            pc_q <= req_i.pc;
        end
        if (r_hs && r_ok) begin
            tag_q <= pc_q[`IFU_XLEN-1:3];
        end
    end

    // ar from captured pc, stable while valid
    always_comb begin
        ar_o       = '0;
        ar_o.valid = (state_q == AR_WAIT);
        ar_o.addr  = {pc_q[`IFU_XLEN-1:3], 3'b000};   // aligned 64-bit word
        ar_o.id    = '0;
        ar_o.len   = 8'd0;                            // single beat
        ar_o.size  = axi_pkg::SIZE_8B;
        ar_o.burst = axi_pkg::BURST_INCR;
        ar_o.prot  = axi_pkg::PROT_DATA;
        ar_o.cache = axi_pkg::CACHE_NONBUF;
    end

    assign r_ready_o    = (state_q == R_WAIT);
    assign wait_en_o    = (state_q == AR_WAIT) || (state_q == R_WAIT);
    assign load_o       = r_hs && r_ok;
    assign deliver_o    = (state_q == DELIVER);
    assign deliver_pc_o = pc_q;
    assign err_o        = deliver_o && err_q;

endmodule

`default_nettype wire

// ==== rtl/fetch_align.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ifu_settings.svh"

module fetch_align (
    input  wire logic                 clock,
    input  wire logic                 reset,
    input  wire logic                 load_i,     // r beat with okay
    input  wire logic [`IFU_XLEN-1:0] data_i,
    input  wire logic                 deliver_i,
    input  wire logic [`IFU_XLEN-1:0] pc_i,
    input  wire logic                 err_i,
    output ifu_pkg::fetch_rsp_t       rsp_o
);

    ifu_pkg::fetch_word_u word_q;   // last good bus word

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            word_q.raw <= '0;
        end else if (load_i) begin
            word_q.raw <= data_i;    // stored raw
        end
    end

    // output straight from the held word
    always_comb begin
        rsp_o.valid = deliver_i;
        rsp_o.pc    = pc_i;
        rsp_o.err   = deliver_i && err_i;
        if (err_i) begin
            rsp_o.instr = 32'h0;                 // no data on error
        end else if (pc_i[2]) begin
            rsp_o.instr = word_q.slot.hi_instr;  // upper half
        end else begin
            rsp_o.instr = word_q.slot.lo_instr;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/rd_wait_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ifu_settings.svh"

module rd_wait_timer (
    input  wire logic clock,
    input  wire logic reset,
    input  wire logic en_i,      // read outstanding
    output logic      expire_o   // one cycle, on the timeout-th enabled cycle
);

    localparam logic [`IFU_TIMER_W-1:0] LAST = `IFU_TIMER_W'(`IFU_RD_TIMEOUT - 1);

    logic [`IFU_TIMER_W-1:0] cnt_q;   // enabled cycles seen so far

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            cnt_q <= '0;
        end else if (!en_i) begin
            cnt_q <= '0;                  // idle clears
        end else if (cnt_q != LAST) begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    // holds at LAST, fsm leaves the wait states on expire
    assign expire_o = en_i && (cnt_q == LAST);

endmodule

`default_nettype wire

// ==== rtl/pc_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ifu_settings.svh"

module pc_gen (
    input  wire logic                 clock,
    input  wire logic                 reset,
    input  wire logic                 redirect_i,
    input  wire logic [`IFU_XLEN-1:0] redirect_pc_i,
    input  wire logic                 advance_i,    // deliver pulse
    input  wire logic                 adv_err_i,    // delivered with error
    output ifu_pkg::fetch_req_t       req_o
);

    logic [`IFU_XLEN-1:0] pc_q;
    logic [`IFU_XLEN-1:0] pend_pc_q;   // remembered redirect target
    logic                 pend_q;
    logic                 run_q;       // low while halted after an error
    logic                 take_redir;
    logic [`IFU_XLEN-1:0] redir_pc;

    // a redirect in the advance cycle counts as pending
    assign take_redir = redirect_i || pend_q;
    assign redir_pc   = redirect_i ? redirect_pc_i : pend_pc_q;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            pc_q   <= `IFU_RESET_PC;
            run_q  <= 1'b1;               // first request right after reset
            pend_q <= 1'b0;
        end else if (!run_q) begin
            if (redirect_i) begin         // restart from halt at once
                pc_q  <= redirect_pc_i;
                run_q <= 1'b1;
            end
        end else if (advance_i) begin
            pend_q <= 1'b0;
            if (take_redir) begin
                pc_q <= redir_pc;         // a known redirect also ends an error halt
            end else if (adv_err_i) begin
                run_q <= 1'b0;            // pc kept at faulting address
            end else begin
                pc_q <= pc_q + `IFU_XLEN'd4;
            end
        end else if (redirect_i) begin
            pend_q <= 1'b1;               // wait for the read in flight
        end
    end

    always_ff @(posedge clock) begin
        if (redirect_i) begin
            pend_pc_q <= redirect_pc_i;
        end
    end

    assign req_o.pc    = pc_q;
    assign req_o.valid = run_q;

endmodule

`default_nettype wire

// ==== rtl/ifu_pkg.sv ====
`default_nettype none

`include "ifu_settings.svh"

package ifu_pkg;

    // request from pc generator, valid is a level
    typedef struct packed {
        logic [`IFU_XLEN-1:0] pc;
        logic                 valid;
    } fetch_req_t;

    // one delivered instruction, valid is a single-cycle pulse
    typedef struct packed {
        logic                 valid;
        logic [`IFU_XLEN-1:0] pc;
        logic [31:0]          instr;
        logic                 err;    // bus error or timeout, instr is zero
    } fetch_rsp_t;

    // two instruction slots of one aligned word
    typedef struct packed {
        logic [31:0] hi_instr;  // pc[2] set
        logic [31:0] lo_instr;  // pc[2] clear
    } fetch_slots_t;

    // bus word as written from r data, read back as slots
    typedef union packed {
        logic [`IFU_XLEN-1:0] raw;
        fetch_slots_t         slot;
    } fetch_word_u;

endpackage

`default_nettype wire

// ==== rtl/axi_pkg.sv ====
`default_nettype none

`include "ifu_settings.svh"

package axi_pkg;

    // read response codes
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } resp_e;

    // fixed ar fields for a single-beat fetch
    localparam logic [1:0] BURST_INCR   = 2'b01;
    localparam logic [2:0] SIZE_8B      = 3'b011;   // 8 bytes per beat
    localparam logic [2:0] PROT_DATA    = 3'b000;   // unprivileged, secure, data
    localparam logic [3:0] CACHE_NONBUF = 4'b0000;  // device, non-bufferable

    // read address channel
    typedef struct packed {
        logic                 valid;
        logic [`IFU_XLEN-1:0] addr;
        logic [`IFU_ID_W-1:0] id;
        logic [7:0]           len;     // beats minus one
        logic [2:0]           size;
        logic [1:0]           burst;
        logic [2:0]           prot;
        logic [3:0]           cache;
    } ar_chan_t;

    // read data channel
    typedef struct packed {
        logic                 valid;
        logic [`IFU_XLEN-1:0] data;
        resp_e                resp;
        logic                 last;
        logic [`IFU_ID_W-1:0] id;
    } r_chan_t;

endpackage

`default_nettype wire

// ==== rtl/ifu_settings.svh ====
`ifndef IFU_SETTINGS_SVH
`define IFU_SETTINGS_SVH

// data and address width of the fetch path
`define IFU_XLEN 64

// axi id width
`define IFU_ID_W 4

// first pc after reset
`define IFU_RESET_PC 64'h0000_0000_8000_0000

// wait cycles before an outstanding read is dropped
`define IFU_RD_TIMEOUT 32

// wide enough to hold IFU_RD_TIMEOUT - 1
`define IFU_TIMER_W 6

`endif
